// ==== tb.f ====
fifo_xbar_pkg.sv
rd_addr_decode.sv
rd_port_arbiter.sv
rd_data_return.sv
ram_bank.sv
shared_read_xbar_top.sv
tb_shared_read_xbar.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_shared_read_xbar
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_shared_read_xbar.sv ====
//--------------------
// Shared read crossbar testbench
// Shadow memory model, round-robin prediction and latency checks
//--------------------

`timescale 1ns/1ps

module tb_shared_read_xbar
  import fifo_xbar_pkg::*;
;

  localparam int MEM_WORDS = 2 ** ADDR_W;
  localparam int RR_READS  = 3 * NUM_FIFOS;
  localparam int RAND_LEN  = 400;
  localparam int MAX_CYCLES = 5 + 10 + MEM_WORDS + RR_READS + 4 * (RAM_LAT + 10) + RAND_LEN + 200;

  logic                  clk;
  logic                  rst_n;
  logic [NUM_FIFOS-1:0]  rd_addr_valid;
  logic [NUM_FIFOS-1:0]  rd_addr_ready;
  addr_t [NUM_FIFOS-1:0] rd_addr;
  logic [NUM_FIFOS-1:0]  rd_data_valid;
  data_t [NUM_FIFOS-1:0] rd_data;
  logic                  ld_en;
  addr_t                 ld_addr;
  data_t                 ld_data;

  data_t shadow [MEM_WORDS];
  addr_t req_q [NUM_FIFOS][$];
  data_t exp_q [NUM_FIFOS][$];
  int    acc_q [NUM_FIFOS][$];
  int    win_log [$];

  logic [NUM_FIFOS-1:0]     acc_seen;
  fifo_id_t [NUM_PORTS-1:0] rr_model;
  int  last_acc [NUM_FIFOS];
  bit  log_grants;
  int  cycle;
  int  data_errs;
  int  lat_errs;
  int  ready_errs;
  int  other_errs;

  shared_read_xbar_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr_ready (rd_addr_ready),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .ld_en         (ld_en),
    .ld_addr       (ld_addr),
    .ld_data       (ld_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------
  // Reference model
  //--------------------

  // Expected read word is whatever was last loaded at that address
  function automatic data_t ref_word(input addr_t a);
    return shadow[a];
  endfunction

  // First requester at or after the pointer, -1 when nobody asks
  function automatic int pick_winner(input logic [NUM_FIFOS-1:0] req, input fifo_id_t ptr);
    int id;
    pick_winner = -1;
    for (int k = NUM_FIFOS - 1; k >= 0; k--) begin
      id = (int'(ptr) + k) % NUM_FIFOS;
      if (req[id]) pick_winner = id;
    end
  endfunction

  function automatic addr_t rand_addr_for_port(input int p);
    addr_t a;
    a = addr_t'($urandom);
    a[PORT_ID_W-1:0] = PORT_ID_W'(p);
    return a;
  endfunction

  //--------------------
  // Compare tasks
  //--------------------

  task automatic check_data(input int f, input data_t got, input data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("FAILED rd_data[%0d]: got 0x%h expected 0x%h", f, got, exp);
    end
  endtask

  task automatic check_latency(input int f, input int got);
    if (got != RAM_LAT) begin
      lat_errs++;
      $display("FAILED rd_data_valid[%0d] latency: got 0x%h expected 0x%h", f, got, RAM_LAT);
    end
  endtask

  task automatic check_ready(input logic [NUM_FIFOS-1:0] got, input logic [NUM_FIFOS-1:0] exp);
    if (got !== exp) begin
      ready_errs++;
      $display("FAILED rd_addr_ready: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  //--------------------
  // Request driver
  //--------------------

  // Each FIFO holds its address until the monitor saw it accepted
  initial begin
    rd_addr_valid = '0;
    rd_addr       = '0;
    forever begin
      @(posedge clk);
      #1;
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (rd_addr_valid[f] && acc_seen[f]) rd_addr_valid[f] = 1'b0;
        acc_seen[f] = 1'b0;
        if (!rd_addr_valid[f] && req_q[f].size() > 0) begin
          rd_addr[f]       = req_q[f].pop_front();
          rd_addr_valid[f] = 1'b1;
        end
      end
    end
  end

  //--------------------
  // Monitor and checker
  //--------------------

  // Sampled mid cycle, where every DUT output has settled
  always @(negedge clk) begin
    logic [NUM_FIFOS-1:0] req;
    logic [NUM_FIFOS-1:0] exp_rdy;
    int win;
    data_t e;
    int c;
    if (!rst_n) begin
      rr_model = '0;
    end else begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (rd_data_valid[f]) begin
          if (exp_q[f].size() == 0) begin
            other_errs++;
            $display("FIFO %0d got read data with no read outstanding at cycle %0d", f, cycle);
          end else begin
            e = exp_q[f].pop_front();
            c = acc_q[f].pop_front();
            check_data(f, rd_data[f], e);
            check_latency(f, cycle - c);
          end
        end
      end
      exp_rdy = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        for (int f = 0; f < NUM_FIFOS; f++) begin
          req[f] = rd_addr_valid[f] && (rd_addr[f][PORT_ID_W-1:0] == PORT_ID_W'(p));
        end
        win = pick_winner(req, rr_model[p]);
        if (win >= 0) begin
          exp_rdy[win] = 1'b1;
          rr_model[p]  = fifo_id_t'((win + 1) % NUM_FIFOS);
        end
      end
      check_ready(rd_addr_ready, exp_rdy);
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (rd_addr_valid[f] && rd_addr_ready[f]) begin
          exp_q[f].push_back(ref_word(rd_addr[f]));
          acc_q[f].push_back(cycle);
          acc_seen[f] = 1'b1;
          last_acc[f] = cycle;
          // Bank 0 acceptances as the DUT made them, in grant order
          if (log_grants && rd_addr[f][PORT_ID_W-1:0] == '0) begin
            win_log.push_back(f);
          end
        end
      end
    end
  end

  // Cycle count doubles as the run limit
  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("Run stopped at cycle %0d, reads never completed", cycle);
      $display("Errors: data=%0d latency=%0d ready=%0d other=%0d",
               data_errs, lat_errs, ready_errs, other_errs + 1);
      $display("Test failed");
      $finish;
    end
  end

  //--------------------
  // Test sequences
  //--------------------

  task automatic load_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      @(posedge clk);
      #1;
      ld_en     = 1'b1;
      ld_addr   = addr_t'(a);
      ld_data   = data_t'($urandom);
      shadow[a] = ld_data;
    end
    @(posedge clk);
    #1;
    ld_en = 1'b0;
  endtask

  task automatic wait_idle();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      #1;
      busy = (rd_addr_valid != '0);
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (req_q[f].size() != 0 || exp_q[f].size() != 0) busy = 1'b1;
      end
    end
  endtask

  initial begin
    int total;
    void'($urandom(32));
    rst_n      = 1'b0;
    ld_en      = 1'b0;
    ld_addr    = '0;
    ld_data    = '0;
    acc_seen   = '0;
    log_grants = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    // Idle bus after reset
    repeat (10) begin
      @(negedge clk);
      if (rd_addr_ready !== '0 || rd_data_valid !== '0) begin
        other_errs++;
        $display("Ready or read data raised while no FIFO was requesting");
      end
    end

    load_memory();

    // Every FIFO hammers bank 0, grants should go 0,1,2,3,0,...
    @(negedge clk);
    #1;
    log_grants = 1'b1;
    for (int r = 0; r < RR_READS / NUM_FIFOS; r++) begin
      for (int f = 0; f < NUM_FIFOS; f++) req_q[f].push_back(rand_addr_for_port(0));
    end
    wait_idle();
    log_grants = 1'b0;
    if (win_log.size() != RR_READS) begin
      other_errs++;
      $display("Round-robin run saw %0d grants instead of %0d", win_log.size(), RR_READS);
    end
    foreach (win_log[i]) begin
      if (win_log[i] != i % NUM_FIFOS) begin
        other_errs++;
        $display("FAILED round-robin grant %0d: got 0x%h expected 0x%h",
                 i, win_log[i], i % NUM_FIFOS);
      end
    end

    // Single read
    @(negedge clk);
    #1;
    req_q[1].push_back(rand_addr_for_port(1));
    wait_idle();

    // Two FIFOs on different banks in the same cycle
    @(negedge clk);
    #1;
    req_q[0].push_back(rand_addr_for_port(0));
    req_q[2].push_back(rand_addr_for_port(1));
    wait_idle();
    if (last_acc[0] != last_acc[2]) begin
      other_errs++;
      $display("Reads on separate banks were not accepted in the same cycle");
    end

    // Random traffic
    repeat (RAND_LEN) begin
      @(negedge clk);
      #1;
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (req_q[f].size() < 2 && $urandom_range(1, 0) == 1) begin
          req_q[f].push_back(addr_t'($urandom));
        end
      end
    end
    wait_idle();

    total = data_errs + lat_errs + ready_errs + other_errs;
    $display("Errors: data=%0d latency=%0d ready=%0d other=%0d",
             data_errs, lat_errs, ready_errs, other_errs);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== shared_read_xbar_top.sv ====
//--------------------
// Shared read crossbar top
// Decode, per port arbiters and banks, and data return
//--------------------

`timescale 1ns/1ps

module shared_read_xbar_top
  import fifo_xbar_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [NUM_FIFOS-1:0]  rd_addr_valid,
  output logic [NUM_FIFOS-1:0]  rd_addr_ready,
  input  addr_t [NUM_FIFOS-1:0] rd_addr,
  output logic [NUM_FIFOS-1:0]  rd_data_valid,
  output data_t [NUM_FIFOS-1:0] rd_data,
  input  logic                  ld_en,
  input  addr_t                 ld_addr,
  input  data_t                 ld_data
);

  logic [NUM_FIFOS-1:0][NUM_PORTS-1:0] port_req;
  logic [NUM_FIFOS-1:0][NUM_PORTS-1:0] port_gnt;

  logic [NUM_PORTS-1:0]       bank_rd_en;
  bank_addr_t [NUM_PORTS-1:0] bank_rd_addr;
  fifo_id_t [NUM_PORTS-1:0]   served_fifo;
  logic [NUM_PORTS-1:0]       bank_data_valid;
  data_t [NUM_PORTS-1:0]      bank_data;

  rd_addr_decode u_decode (
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .port_gnt      (port_gnt),
    .port_req      (port_req),
    .rd_addr_ready (rd_addr_ready)
  );

  //--------------------
  // Per port slice
  //--------------------

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // Column of the request and grant matrices that belongs to this bank
    logic [NUM_FIFOS-1:0] col_req;
    logic [NUM_FIFOS-1:0] col_gnt;

    for (genvar f = 0; f < NUM_FIFOS; f++) begin : g_col
      assign col_req[f]     = port_req[f][p];
      assign port_gnt[f][p] = col_gnt[f];
    end

    rd_port_arbiter u_arb (
      .clk          (clk),
      .rst_n        (rst_n),
      .port_req     (col_req),
      .rd_addr      (rd_addr),
      .port_gnt     (col_gnt),
      .bank_rd_en   (bank_rd_en[p]),
      .bank_rd_addr (bank_rd_addr[p]),
      .served_fifo  (served_fifo[p])
    );

    ram_bank #(
      .BANK_ID (p)
    ) u_bank (
      .clk             (clk),
      .rst_n           (rst_n),
      .bank_rd_en      (bank_rd_en[p]),
      .bank_rd_addr    (bank_rd_addr[p]),
      .ld_en           (ld_en),
      .ld_addr         (ld_addr),
      .ld_data         (ld_data),
      .bank_data_valid (bank_data_valid[p]),
      .bank_data       (bank_data[p])
    );
  end

  rd_data_return u_return (
    .clk             (clk),
    .rst_n           (rst_n),
    .bank_rd_en      (bank_rd_en),
    .served_fifo     (served_fifo),
    .bank_data_valid (bank_data_valid),
    .bank_data       (bank_data),
    .rd_data_valid   (rd_data_valid),
    .rd_data         (rd_data)
  );

endmodule

// ==== ram_bank.sv ====
//--------------------
// RAM bank
// One synchronous bank with fixed read latency and a load port
//--------------------

`timescale 1ns/1ps

module ram_bank
  import fifo_xbar_pkg::*;
#(
  parameter int unsigned BANK_ID = 0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       bank_rd_en,
  input  bank_addr_t bank_rd_addr,
  input  logic       ld_en,
  input  addr_t      ld_addr,
  input  data_t      ld_data,
  output logic       bank_data_valid,
  output data_t      bank_data
);

  data_t mem [BANK_DEPTH];

  // Read pipeline, stage 0 is the array read
  data_t [RAM_LAT-1:0] data_pipe;
  logic [RAM_LAT-1:0]  vld_pipe;

  logic ld_hit;

  // Loads carry a full FIFO address, only those for this bank land here
  assign ld_hit = ld_en && (ld_addr[PORT_ID_W-1:0] == PORT_ID_W'(BANK_ID));

  // Read samples before the write lands, so a same cycle load returns old data
  always_ff @(posedge clk) begin
    if (ld_hit) begin
      mem[ld_addr[ADDR_W-1:PORT_ID_W]] <= ld_data;
    end
    data_pipe[0] <= mem[bank_rd_addr];
    for (int s = 1; s < RAM_LAT; s++) begin
      data_pipe[s] <= data_pipe[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= bank_rd_en;
      for (int s = 1; s < RAM_LAT; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  assign bank_data_valid = vld_pipe[RAM_LAT-1];
  assign bank_data       = data_pipe[RAM_LAT-1];

endmodule

// ==== rd_data_return.sv ====
//--------------------
// Read data return
// Tracks the served FIFO per port over the RAM latency and routes data back
//--------------------

`timescale 1ns/1ps

module rd_data_return
  import fifo_xbar_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [NUM_PORTS-1:0]     bank_rd_en,
  input  fifo_id_t [NUM_PORTS-1:0] served_fifo,
  input  logic [NUM_PORTS-1:0]     bank_data_valid,
  input  data_t [NUM_PORTS-1:0]    bank_data,
  output logic [NUM_FIFOS-1:0]     rd_data_valid,
  output data_t [NUM_FIFOS-1:0]    rd_data
);

  // Per port delay line of FIFO ids and matching valid bits
  fifo_id_t [RAM_LAT-1:0]             id_pipe [NUM_PORTS];
  logic [NUM_PORTS-1:0][RAM_LAT-1:0]  vld_pipe;

  // Last stage of each line, lined up with bank data
  fifo_id_t [NUM_PORTS-1:0] id_out;
  logic [NUM_PORTS-1:0]     vld_out;

  // Which port returns data to which FIFO this cycle
  logic [NUM_FIFOS-1:0][NUM_PORTS-1:0] hit;

  //--------------------
  // FIFO id delay line
  //--------------------

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      id_pipe[p][0] <= served_fifo[p];
      for (int s = 1; s < RAM_LAT; s++) begin
        id_pipe[p][s] <= id_pipe[p][s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        vld_pipe[p][0] <= bank_rd_en[p];
        for (int s = 1; s < RAM_LAT; s++) begin
          vld_pipe[p][s] <= vld_pipe[p][s-1];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      id_out[p]  = id_pipe[p][RAM_LAT-1];
      vld_out[p] = vld_pipe[p][RAM_LAT-1];
    end
  end

  //--------------------
  // Data demux
  //--------------------

  // Bank data goes straight out to the FIFO the delay line names
  always_comb begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      rd_data[f] = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        hit[f][p]  = bank_data_valid[p] && (id_out[p] == fifo_id_t'(f));
        rd_data[f] = rd_data[f] | (bank_data[p] & {DATA_W{hit[f][p]}});
      end
      rd_data_valid[f] = |hit[f];
    end
  end

  // The banks must return data exactly when the id tracker expects it
  a_bank_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    vld_out == bank_data_valid
  ) else $error("rd_data_return: bank data out of step with tracked reads");

  // A FIFO has one read in flight per cycle, so two ports never answer it at once
  for (genvar f = 0; f < NUM_FIFOS; f++) begin : g_fifo_chk
    a_single_source: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(hit[f])
    ) else $error("rd_data_return: FIFO %0d served by two ports", f);
  end

endmodule

// ==== rd_port_arbiter.sv ====
//--------------------
// Read port arbiter
// Round-robin choice among FIFOs that target this bank, issues the bank read
//--------------------

`timescale 1ns/1ps

module rd_port_arbiter
  import fifo_xbar_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [NUM_FIFOS-1:0]  port_req,
  input  addr_t [NUM_FIFOS-1:0] rd_addr,
  output logic [NUM_FIFOS-1:0]  port_gnt,
  output logic                  bank_rd_en,
  output bank_addr_t            bank_rd_addr,
  output fifo_id_t              served_fifo
);

  // Highest priority FIFO for the next grant
  fifo_id_t rr_ptr;

  // Search results
  fifo_id_t cand_id;
  fifo_id_t win_id;
  logic     win_found;

  //--------------------
  // Priority search
  //--------------------

  // Walk the FIFOs starting at the pointer and take the first request seen
  always_comb begin
    win_found = 1'b0;
    win_id    = '0;
    cand_id   = '0;
    for (int k = 0; k < NUM_FIFOS; k++) begin
      cand_id = fifo_id_t'((int'(rr_ptr) + k) % NUM_FIFOS);
      if (!win_found && port_req[cand_id]) begin
        win_found = 1'b1;
        win_id    = cand_id;
      end
    end
  end

  always_comb begin
    port_gnt = '0;
    if (win_found) begin
      port_gnt[win_id] = 1'b1;
    end
  end

  //--------------------
  // Bank read issue
  //--------------------

  // Grant and bank read happen in the same cycle, so the winner is accepted now
  assign bank_rd_en  = win_found;
  assign served_fifo = win_id;

  // Drop the bank select bits, they are implied by which bank we drive
  assign bank_rd_addr = rd_addr[win_id][ADDR_W-1:PORT_ID_W];

  // Pointer moves just past the winner so it gets lowest priority next time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (win_found) begin
      rr_ptr <= fifo_id_t'((int'(win_id) + 1) % NUM_FIFOS);
    end
  end

  //--------------------
  // Checks
  //--------------------

  // At most one FIFO is granted on this bank per cycle
  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(port_gnt)
  ) else $error("rd_port_arbiter: more than one grant");

  // Work conserving, a pending request always produces a grant
  a_gnt_when_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|port_req) |-> (|port_gnt)
  ) else $error("rd_port_arbiter: requests pending but no grant");

endmodule

// ==== rd_addr_decode.sv ====
//--------------------
// Read address decode
// Steers each FIFO read request to the bank chosen by its low address bits
//--------------------

`timescale 1ns/1ps

module rd_addr_decode
  import fifo_xbar_pkg::*;
(
  input  logic [NUM_FIFOS-1:0]                rd_addr_valid,
  input  addr_t [NUM_FIFOS-1:0]               rd_addr,
  input  logic [NUM_FIFOS-1:0][NUM_PORTS-1:0] port_gnt,
  output logic [NUM_FIFOS-1:0][NUM_PORTS-1:0] port_req,
  output logic [NUM_FIFOS-1:0]                rd_addr_ready
);

  // Bank selected by each FIFO's current address
  logic [NUM_FIFOS-1:0][PORT_ID_W-1:0] fifo_port_id;

  //--------------------
  // Request steering
  //--------------------

  always_comb begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      fifo_port_id[f] = rd_addr[f][PORT_ID_W-1:0];
    end
  end

  // A FIFO requests exactly one bank, and only while it holds a valid address
  always_comb begin
    port_req = '0;
    for (int f = 0; f < NUM_FIFOS; f++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (rd_addr_valid[f] && (fifo_port_id[f] == PORT_ID_W'(p))) begin
          port_req[f][p] = 1'b1;
        end
      end
    end
  end

  //--------------------
  // Ready collection
  //--------------------

  // Ready is the grant from the bank this FIFO is pointing at
  always_comb begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      rd_addr_ready[f] = port_gnt[f][fifo_port_id[f]];
    end
  end

  // The arbiters must never grant a FIFO on a bank it is not addressing.
  // This ties the decode steering to the grant logic in every arbiter
  always_comb begin
    a_gnt_only_on_req: assert final ((port_gnt & ~port_req) == '0)
      else $error("rd_addr_decode: grant without a matching request");
  end

endmodule

// ==== fifo_xbar_pkg.sv ====
//--------------------
// Shared read crossbar definitions
// Sizes, widths, RAM latency and vector types used across the design
//--------------------

package fifo_xbar_pkg;

  //--------------------
  // Sizes
  //--------------------

  // Logical FIFOs that share the banked RAM
  localparam int NUM_FIFOS = 4;

  // One RAM bank per read port, always a power of two
  localparam int NUM_PORTS = 2;

  // Low address bits pick the bank
  localparam int PORT_ID_W = $clog2(NUM_PORTS);
  localparam int FIFO_ID_W = $clog2(NUM_FIFOS);

  localparam int ADDR_W      = 8;
  localparam int BANK_ADDR_W = ADDR_W - PORT_ID_W;
  localparam int BANK_DEPTH  = 2 ** BANK_ADDR_W;
  localparam int DATA_W      = 16;

  // Cycles from bank read enable to bank data, at least 1
  localparam int RAM_LAT = 2;

  //--------------------
  // Vector types
  //--------------------

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [FIFO_ID_W-1:0]   fifo_id_t;

endpackage
